// File: compile.f
verilog/dcache_pkg.sv
verilog/dcache_dpsram.sv
verilog/dcache_array.sv
verilog/dcache_lookup.sv
verilog/dcache_line_port.sv
verilog/dcache_top.sv
dv/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - verilog/dcache_pkg.sv
  - verilog/dcache_dpsram.sv
  - verilog/dcache_array.sv
  - verilog/dcache_lookup.sv
  - verilog/dcache_line_port.sv
  - verilog/dcache_top.sv
  - target: test
    files:
      - dv/dcache_tb.sv

// File: dv/dcache_tb.sv
// directed tests with a reference model; first mismatch or a missing response ends the run
`timescale 1ns/1ns

module dcache_tb;

  logic                  clk;
  logic                  arst_n_i;
  logic                  load_valid_i;
  dcache_pkg::load_req_t load_req_i;
  logic                  load_valid_o;
  dcache_pkg::load_rsp_t load_rsp_o;
  logic                  line_valid_i;
  dcache_pkg::line_req_t line_req_i;
  logic                  line_valid_o;
  dcache_pkg::line_rsp_t line_rsp_o;

  int seed;
  int cycle;

  // reference model holds one entry per set and way
  logic [dcache_pkg::TAG_W-1:0]  mdl_tag [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];
  bit                            mdl_valid [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS];
  logic [dcache_pkg::WORD_W-1:0] mdl_data [dcache_pkg::NUM_SETS][dcache_pkg::NUM_WAYS]
                                          [dcache_pkg::LINE_WORDS];

  dcache_pkg::load_rsp_t load_exp [$];
  int                    load_due [$];  // cycle in which the response must show
  dcache_pkg::line_rsp_t line_exp [$];
  int                    line_due [$];
  dcache_pkg::line_rsp_t line_head;

  dcache_top u_dcache_top (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .load_valid_i (load_valid_i),
    .load_req_i   (load_req_i),
    .load_valid_o (load_valid_o),
    .load_rsp_o   (load_rsp_o),
    .line_valid_i (line_valid_i),
    .line_req_i   (line_req_i),
    .line_valid_o (line_valid_o),
    .line_rsp_o   (line_rsp_o)
  );

  always #2 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_val(input logic [159:0] got, input logic [159:0] exp, input string msg);
    if (got !== exp)
    begin
      stop_run($sformatf("[FAIL] %0t %s: got %0h expected %0h", $time, msg, got, exp));
    end
  endtask

  function automatic dcache_pkg::cache_addr_t make_addr(input logic [19:0] tag,
                                                        input logic [7:0] idx,
                                                        input logic [1:0] word);
    dcache_pkg::cache_addr_t a;
    a.tag   = tag;
    a.index = idx;
    a.word  = word;
    a.boff  = '0;
    return a;
  endfunction

  function automatic dcache_pkg::line_req_t make_line(input logic [19:0] tag,
                                                      input logic [7:0] idx,
                                                      input logic [1:0] way, input logic wr,
                                                      input logic [15:0] strb);
    dcache_pkg::line_req_t r;
    r       = '0;
    r.addr  = make_addr(tag, idx, 2'd0);
    r.way   = way;
    r.write = wr;
    r.strb  = strb;
    for (int w = 0; w < dcache_pkg::LINE_WORDS; w++)
    begin
      r.data[w] = $random(seed);  // fresh data every line
    end
    return r;
  endfunction

  // strobed bytes take the new value and others keep the old one
  task automatic apply_write(input dcache_pkg::line_req_t r);
    mdl_tag[r.addr.index][r.way]   = r.addr.tag;
    mdl_valid[r.addr.index][r.way] = 1'b1;
    for (int w = 0; w < dcache_pkg::LINE_WORDS; w++)
    begin
      for (int b = 0; b < dcache_pkg::WSTRB_W; b++)
      begin
        if (r.strb[w][b])
        begin
          mdl_data[r.addr.index][r.way][w][8*b +: 8] = r.data[w][8*b +: 8];
        end
      end
    end
  endtask

  function automatic dcache_pkg::load_rsp_t expect_load(input dcache_pkg::cache_addr_t a);
    dcache_pkg::load_rsp_t e;
    e = '0;  // miss gives zero data and way
    for (int v = 0; v < dcache_pkg::NUM_WAYS; v++)
    begin
      if (!e.hit && mdl_valid[a.index][v] && mdl_tag[a.index][v] == a.tag)
      begin
        e.hit  = 1'b1;
        e.way  = v;
        e.data = mdl_data[a.index][v][a.word];
      end
    end
    return e;
  endfunction

  function automatic dcache_pkg::line_rsp_t expect_line(input dcache_pkg::line_req_t r);
    dcache_pkg::line_rsp_t e;
    e.tag.valid = mdl_valid[r.addr.index][r.way];
    e.tag.tag   = mdl_tag[r.addr.index][r.way];
    for (int w = 0; w < dcache_pkg::LINE_WORDS; w++)
    begin
      e.data[w] = mdl_data[r.addr.index][r.way][w];
    end
    return e;
  endfunction

  // one cycle of stimulus on both ports
  task automatic issue(input logic ld, input dcache_pkg::cache_addr_t la,
                       input logic ln, input dcache_pkg::line_req_t lr);
    @(posedge clk);
    load_valid_i    <= ld;
    load_req_i.addr <= la;
    line_valid_i    <= ln;
    line_req_i      <= lr;
    if (ln && lr.write)
    begin
      apply_write(lr);  // a same-cycle write is visible to the load
    end
    if (ld)
    begin
      load_exp.push_back(expect_load(la));
      load_due.push_back(cycle + 2);
    end
    if (ln && !lr.write)
    begin
      line_exp.push_back(expect_line(lr));
      line_due.push_back(cycle + 2);
    end
  endtask

  task automatic send_load(input logic [19:0] tag, input logic [7:0] idx, input logic [1:0] word);
    issue(1'b1, make_addr(tag, idx, word), 1'b0, '0);
  endtask

  task automatic send_write(input logic [19:0] tag, input logic [7:0] idx,
                            input logic [1:0] way, input logic [15:0] strb);
    issue(1'b0, '0, 1'b1, make_line(tag, idx, way, 1'b1, strb));
  endtask

  task automatic send_read(input logic [7:0] idx, input logic [1:0] way);
    issue(1'b0, '0, 1'b1, make_line('0, idx, way, 1'b0, '0));
  endtask

  task automatic drain();
    int n;
    issue(1'b0, '0, 1'b0, '0);
    n = 0;
    while ((load_exp.size() != 0 || line_exp.size() != 0) && n < 20)
    begin
      @(posedge clk);
      n++;
    end
    if (load_exp.size() != 0 || line_exp.size() != 0)
    begin
      stop_run("no response arrived within 20 cycles");
    end
  endtask

  always @(negedge clk)
  begin
    if (arst_n_i && load_valid_o)
    begin
      if (load_exp.size() == 0)
      begin
        stop_run("load response arrived with no load pending");
      end
      else
      begin
        check_val(cycle, load_due.pop_front(), "load latency");
        check_val(load_rsp_o, load_exp.pop_front(), "load response");
      end
    end
  end

  always @(negedge clk)
  begin
    if (arst_n_i && line_valid_o)
    begin
      if (line_exp.size() == 0)
      begin
        stop_run("line response arrived with no line read pending");
      end
      else
      begin
        check_val(cycle, line_due.pop_front(), "line latency");
        line_head = line_exp.pop_front();
        if (line_head.tag.valid)
        begin
          check_val(line_rsp_o, line_head, "line response");
        end
        else
        begin
          check_val(line_rsp_o.tag.valid, line_head.tag.valid, "line tag valid");
        end
      end
    end
  end

  task automatic reset_misses();
    send_load($random(seed), 8'h00, 2'd0);
    send_load($random(seed), 8'h05, 2'd3);
    send_load($random(seed), 8'h80, 2'd1);
    send_load($random(seed), 8'hff, 2'd2);
    send_read(8'h12, 2'd2);  // never written so valid must be clear
    drain();
  endtask

  task automatic single_way_fill();
    send_write(20'h0abcd, 8'h10, 2'd1, 16'hffff);
    for (int w = 0; w < dcache_pkg::LINE_WORDS; w++)
    begin
      send_load(20'h0abcd, 8'h10, w);
    end
    send_load(20'h0abce, 8'h10, 2'd0);  // other tag misses
    drain();
  endtask

  task automatic all_ways_skew();
    for (int v = 0; v < dcache_pkg::NUM_WAYS; v++)
    begin
      send_write(20'h00100 + v, 8'h20, v, 16'hffff);
    end
    for (int v = 0; v < dcache_pkg::NUM_WAYS; v++)
    begin
      for (int w = 0; w < dcache_pkg::LINE_WORDS; w++)
      begin
        send_load(20'h00100 + v, 8'h20, w);  // back to back
      end
    end
    drain();
  endtask

  task automatic partial_strobe_merge();
    send_write(20'h03333, 8'h30, 2'd2, 16'hffff);
    send_write(20'h04444, 8'h30, 2'd2, 16'h5a3c);
    send_read(8'h30, 2'd2);
    drain();
  endtask

  task automatic same_cycle_forward();
    for (int w = 0; w < dcache_pkg::LINE_WORDS; w++)
    begin
      issue(1'b1, make_addr(20'h00500 + w, 8'h44, w),
            1'b1, make_line(20'h00500 + w, 8'h44, w, 1'b1, 16'hffff));
    end
    drain();
  endtask

  task automatic random_mix();
    logic [31:0] r;
    logic [31:0] s;
    // full lines first so every byte is known
    for (int v = 0; v < dcache_pkg::NUM_WAYS; v++)
    begin
      for (int i = 0; i < 4; i++)
      begin
        send_write(20'h00700 + v, 8'h60 + i, v, 16'hffff);
      end
    end
    for (int n = 0; n < 200; n++)
    begin
      r = $random(seed);
      s = $random(seed);
      issue(r[0], make_addr(20'h00700 + r[2:1], 8'h60 + r[4:3], r[6:5]),
            r[7], make_line(20'h00700 + r[9:8], 8'h60 + r[11:10], r[13:12], r[14], s[15:0]));
    end
    drain();
  endtask

  initial
  begin
    seed         = 32'h1002;
    clk          = 1'b0;
    arst_n_i     = 1'b0;
    load_valid_i = 1'b0;
    load_req_i   = '0;
    line_valid_i = 1'b0;
    line_req_i   = '0;
    repeat (8) @(posedge clk);
    arst_n_i <= 1'b1;
    reset_misses();
    single_way_fill();
    all_ways_skew();
    partial_strobe_merge();
    same_cycle_forward();
    random_mix();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: verilog/dcache_top.sv
// both ports may strobe every cycle; responses must be taken in the cycle they are valid
`timescale 1ns/1ns

module dcache_top (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic                  load_valid_i,
  input  dcache_pkg::load_req_t load_req_i,
  output logic                  load_valid_o,
  output dcache_pkg::load_rsp_t load_rsp_o,
  input  logic                  line_valid_i,
  input  dcache_pkg::line_req_t line_req_i,
  output logic                  line_valid_o,
  output dcache_pkg::line_rsp_t line_rsp_o
);

  logic [dcache_pkg::IDX_W+dcache_pkg::WSEL_W-1:0]                p_addr;
  logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::WORD_W-1:0]        p_rdata;
  dcache_pkg::cache_tag_t [dcache_pkg::NUM_WAYS-1:0]              p_rtag;
  logic [dcache_pkg::WAY_W-1:0]                                   m_way;
  logic [dcache_pkg::IDX_W-1:0]                                   m_index;
  logic [dcache_pkg::LINE_WORDS-1:0][dcache_pkg::WSTRB_W-1:0]     m_wstrb;
  logic [dcache_pkg::LINE_WORDS-1:0][dcache_pkg::WORD_W-1:0]      m_wdata;
  logic [dcache_pkg::LINE_WORDS-1:0][dcache_pkg::WORD_W-1:0]      m_rdata;
  logic [dcache_pkg::IDX_W-1:0]                                   t_index;
  logic [dcache_pkg::NUM_WAYS-1:0]                                t_we;
  dcache_pkg::cache_tag_t                                         t_wtag;
  dcache_pkg::cache_tag_t [dcache_pkg::NUM_WAYS-1:0]              t_rtag;

  dcache_lookup u_lookup (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .load_valid_i (load_valid_i),
    .load_req_i   (load_req_i),
    .p_addr_o     (p_addr),
    .p_rdata_i    (p_rdata),
    .p_rtag_i     (p_rtag),
    .load_valid_o (load_valid_o),
    .load_rsp_o   (load_rsp_o)
  );

  dcache_line_port u_line_port (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .line_valid_i (line_valid_i),
    .line_req_i   (line_req_i),
    .m_way_o      (m_way),
    .m_index_o    (m_index),
    .m_wstrb_o    (m_wstrb),
    .m_wdata_o    (m_wdata),
    .m_rdata_i    (m_rdata),
    .t_index_o    (t_index),
    .t_we_o       (t_we),
    .t_wtag_o     (t_wtag),
    .t_rtag_i     (t_rtag),
    .line_valid_o (line_valid_o),
    .line_rsp_o   (line_rsp_o)
  );

  dcache_array u_array (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .p_addr_i  (p_addr),
    .p_rdata_o (p_rdata),
    .p_rtag_o  (p_rtag),
    .m_way_i   (m_way),
    .m_index_i (m_index),
    .m_wstrb_i (m_wstrb),
    .m_wdata_i (m_wdata),
    .m_rdata_o (m_rdata),
    .t_index_i (t_index),
    .t_we_i    (t_we),
    .t_wtag_i  (t_wtag),
    .t_rtag_o  (t_rtag)
  );

endmodule

// File: verilog/dcache_line_port.sv
// writes give no response; a line read answers the next cycle with the way's tag and whole line
`timescale 1ns/1ns

module dcache_line_port (
  input  logic                                                        clk,
  input  logic                                                        arst_n_i,
  input  logic                                                        line_valid_i,
  input  dcache_pkg::line_req_t                                       line_req_i,
  output logic [dcache_pkg::WAY_W-1:0]                                m_way_o,
  output logic [dcache_pkg::IDX_W-1:0]                                m_index_o,
  output logic [dcache_pkg::LINE_WORDS-1:0][dcache_pkg::WSTRB_W-1:0]  m_wstrb_o,
  output logic [dcache_pkg::LINE_WORDS-1:0][dcache_pkg::WORD_W-1:0]   m_wdata_o,
  input  logic [dcache_pkg::LINE_WORDS-1:0][dcache_pkg::WORD_W-1:0]   m_rdata_i,
  output logic [dcache_pkg::IDX_W-1:0]                                t_index_o,
  output logic [dcache_pkg::NUM_WAYS-1:0]                             t_we_o,
  output dcache_pkg::cache_tag_t                                      t_wtag_o,
  input  dcache_pkg::cache_tag_t [dcache_pkg::NUM_WAYS-1:0]           t_rtag_i,
  output logic                                                        line_valid_o,
  output dcache_pkg::line_rsp_t                                       line_rsp_o
);

  logic                         wr_en;
  logic                         rd_valid_q;
  logic [dcache_pkg::WAY_W-1:0] way_q;

  assign wr_en = line_valid_i && line_req_i.write;

  assign m_way_o   = line_req_i.way;
  assign m_index_o = line_req_i.addr.index;
  assign m_wstrb_o = wr_en ? line_req_i.strb : '0;  // all zero is a plain read
  assign m_wdata_o = line_req_i.data;

  assign t_index_o = line_req_i.addr.index;
  assign t_wtag_o  = '{valid: 1'b1, tag: line_req_i.addr.tag};

  always_comb
  begin
    for (int v = 0; v < dcache_pkg::NUM_WAYS; v++)
    begin
      t_we_o[v] = wr_en && (line_req_i.way == v);
    end
  end

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rd_valid_q <= 1'b0;
    end
    else
    begin
      rd_valid_q <= line_valid_i && !line_req_i.write;
    end
  end

  always_ff @(posedge clk)
  begin
    if (line_valid_i)
    begin
      way_q <= line_req_i.way;
    end
  end

  assign line_valid_o    = rd_valid_q;
  assign line_rsp_o.tag  = t_rtag_i[way_q];
  assign line_rsp_o.data = m_rdata_i;  // already rotated into word order

endmodule

// File: verilog/dcache_lookup.sv
// no back-pressure; load_rsp_o is valid only in the cycle load_valid_o is high, lowest hitting way wins
`timescale 1ns/1ns

module dcache_lookup (
  input  logic                                                     clk,
  input  logic                                                     arst_n_i,
  input  logic                                                     load_valid_i,
  input  dcache_pkg::load_req_t                                    load_req_i,
  output logic [dcache_pkg::IDX_W+dcache_pkg::WSEL_W-1:0]          p_addr_o,
  input  logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::WORD_W-1:0]  p_rdata_i,
  input  dcache_pkg::cache_tag_t [dcache_pkg::NUM_WAYS-1:0]        p_rtag_i,
  output logic                                                     load_valid_o,
  output dcache_pkg::load_rsp_t                                    load_rsp_o
);

  logic                            valid_q;
  logic [dcache_pkg::TAG_W-1:0]    tag_q;
  logic [dcache_pkg::NUM_WAYS-1:0] hit_vec;
  logic                            hit;
  logic [dcache_pkg::WAY_W-1:0]    hit_way;

  // decode: index and word straight to the RAMs
  assign p_addr_o = {load_req_i.addr.index, load_req_i.addr.word};

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= load_valid_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load_valid_i)
    begin
      tag_q <= load_req_i.addr.tag;  // held for the compare
    end
  end

  // execute
  always_comb
  begin
    for (int v = 0; v < dcache_pkg::NUM_WAYS; v++)
    begin
      hit_vec[v] = p_rtag_i[v].valid && (p_rtag_i[v].tag == tag_q);
    end
  end

  // result: scan down so the lowest way is taken last
  always_comb
  begin
    hit     = 1'b0;
    hit_way = '0;
    for (int v = dcache_pkg::NUM_WAYS - 1; v >= 0; v--)
    begin
      if (hit_vec[v])
      begin
        hit     = 1'b1;
        hit_way = v[dcache_pkg::WAY_W-1:0];
      end
    end
  end

  always_comb
  begin
    load_rsp_o.hit  = hit;
    load_rsp_o.way  = hit_way;              // zero on a miss
    load_rsp_o.data = hit ? p_rdata_i[hit_way] : '0;
  end

  assign load_valid_o = valid_q;

endmodule

// File: verilog/dcache_array.sv
// all outputs are one cycle after their address; a P read colliding with an M/T write gets the new value
`timescale 1ns/1ns

module dcache_array (
  input  logic                                                        clk,
  input  logic                                                        arst_n_i,
  input  logic [dcache_pkg::IDX_W+dcache_pkg::WSEL_W-1:0]             p_addr_i,
  output logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::WORD_W-1:0]     p_rdata_o,
  output dcache_pkg::cache_tag_t [dcache_pkg::NUM_WAYS-1:0]           p_rtag_o,
  input  logic [dcache_pkg::WAY_W-1:0]                                m_way_i,
  input  logic [dcache_pkg::IDX_W-1:0]                                m_index_i,
  input  logic [dcache_pkg::LINE_WORDS-1:0][dcache_pkg::WSTRB_W-1:0]  m_wstrb_i,
  input  logic [dcache_pkg::LINE_WORDS-1:0][dcache_pkg::WORD_W-1:0]   m_wdata_i,
  output logic [dcache_pkg::LINE_WORDS-1:0][dcache_pkg::WORD_W-1:0]   m_rdata_o,
  input  logic [dcache_pkg::IDX_W-1:0]                                t_index_i,
  input  logic [dcache_pkg::NUM_WAYS-1:0]                             t_we_i,
  input  dcache_pkg::cache_tag_t                                      t_wtag_i,
  output dcache_pkg::cache_tag_t [dcache_pkg::NUM_WAYS-1:0]           t_rtag_o
);

  logic [dcache_pkg::IDX_W-1:0]                                   p_index;
  logic [dcache_pkg::WSEL_W-1:0]                                  p_word_q;
  logic [dcache_pkg::WAY_W-1:0]                                   m_way_q;
  logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::WORD_W-1:0]        bank_p;  // per bank, P side
  logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::WORD_W-1:0]        bank_m;  // per bank, M side

  assign p_index = p_addr_i[dcache_pkg::IDX_W+dcache_pkg::WSEL_W-1:dcache_pkg::WSEL_W];

  for (genvar w = 0; w < dcache_pkg::NUM_WAYS; w++)
  begin : g_tag
    dcache_pkg::cache_tag_t          rtag0;
    dcache_pkg::cache_tag_t          rtag1;
    logic [dcache_pkg::NUM_SETS-1:0] valid_q;
    logic                            p_valid_q;
    logic                            t_valid_q;
    logic                            conflict;
    logic                            conflict_q;

    assign conflict = (p_index == t_index_i) && t_we_i[w];

    // valid bits live in flops so reset can clear them
    always_ff @(posedge clk or negedge arst_n_i)
    begin
      if (!arst_n_i)
      begin
        valid_q    <= '0;
        p_valid_q  <= 1'b0;
        t_valid_q  <= 1'b0;
        conflict_q <= 1'b0;
      end
      else
      begin
        if (t_we_i[w])
        begin
          valid_q[t_index_i] <= t_wtag_i.valid;
        end
        p_valid_q  <= conflict ? t_wtag_i.valid : valid_q[p_index];
        t_valid_q  <= t_we_i[w] ? t_wtag_i.valid : valid_q[t_index_i];
        conflict_q <= conflict;
      end
    end

    assign p_rtag_o[w] = '{valid: p_valid_q, tag: conflict_q ? rtag1.tag : rtag0.tag};
    assign t_rtag_o[w] = '{valid: t_valid_q, tag: rtag1.tag};

    dcache_dpsram #(
      .DATA_W ($bits(dcache_pkg::cache_tag_t)),
      .DEPTH  (dcache_pkg::NUM_SETS)
    ) u_tag_ram (
      .clk      (clk),
      .addr0_i  (p_index),
      .en0_i    (!conflict),  // port 1 supplies the data instead
      .rdata0_o (rtag0),
      .addr1_i  (t_index_i),
      .en1_i    (1'b1),
      .we1_i    ({(($bits(dcache_pkg::cache_tag_t) + 7) / 8){t_we_i[w]}}),
      .wdata1_i (t_wtag_i),
      .rdata1_o (rtag1)
    );
  end

  // bank b holds word (b - way) of each way, so one word per bank per line
  for (genvar b = 0; b < dcache_pkg::NUM_WAYS; b++)
  begin : g_bank
    logic [dcache_pkg::WSEL_W-1:0]               m_slot;
    logic [dcache_pkg::IDX_W+dcache_pkg::WSEL_W-1:0] m_addr;
    logic                                        conflict;
    logic                                        conflict_q;
    logic [dcache_pkg::WORD_W-1:0]               rdata0;

    assign m_slot   = b[dcache_pkg::WSEL_W-1:0] - m_way_i;
    assign m_addr   = {m_index_i, m_slot};
    assign conflict = (p_addr_i == m_addr);

    always_ff @(posedge clk or negedge arst_n_i)
    begin
      if (!arst_n_i)
      begin
        conflict_q <= 1'b0;
      end
      else
      begin
        conflict_q <= conflict;
      end
    end

    assign bank_p[b] = conflict_q ? bank_m[b] : rdata0;

    dcache_dpsram #(
      .DATA_W (dcache_pkg::WORD_W),
      .DEPTH  (dcache_pkg::NUM_SETS * dcache_pkg::LINE_WORDS)
    ) u_data_ram (
      .clk      (clk),
      .addr0_i  (p_addr_i),
      .en0_i    (!conflict),
      .rdata0_o (rdata0),
      .addr1_i  (m_addr),
      .en1_i    (1'b1),
      .we1_i    (m_wstrb_i[m_slot]),
      .wdata1_i (m_wdata_i[m_slot]),
      .rdata1_o (bank_m[b])
    );
  end

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      p_word_q <= '0;
      m_way_q  <= '0;
    end
    else
    begin
      p_word_q <= p_addr_i[dcache_pkg::WSEL_W-1:0];
      m_way_q  <= m_way_i;
    end
  end

  // undo the skew on both read paths
  always_comb
  begin
    for (int i = 0; i < dcache_pkg::NUM_WAYS; i++)
    begin
      p_rdata_o[i] = bank_p[i[dcache_pkg::WSEL_W-1:0] + p_word_q];  // way i
      m_rdata_o[i] = bank_m[i[dcache_pkg::WSEL_W-1:0] + m_way_q];   // word i
    end
  end

endmodule

// File: verilog/dcache_dpsram.sv
// port 0 only reads and sees old data when port 1 writes the same word; contents start undefined
`timescale 1ns/1ns

module dcache_dpsram #(
  parameter int DATA_W = dcache_pkg::WORD_W,
  parameter int DEPTH  = dcache_pkg::NUM_SETS
) (
  input  logic                     clk,
  input  logic [$clog2(DEPTH)-1:0] addr0_i,
  input  logic                     en0_i,
  output logic [DATA_W-1:0]        rdata0_o,
  input  logic [$clog2(DEPTH)-1:0] addr1_i,
  input  logic                     en1_i,
  input  logic [(DATA_W+7)/8-1:0]  we1_i,    // one bit per byte, top lane may be partial
  input  logic [DATA_W-1:0]        wdata1_i,
  output logic [DATA_W-1:0]        rdata1_o
);

  logic [DATA_W-1:0] mem [DEPTH];
  logic [DATA_W-1:0] merged;  // old word with the enabled bytes replaced

  always_comb
  begin
    merged = mem[addr1_i];
    for (int i = 0; i < DATA_W; i++)
    begin
      if (we1_i[i/8])
      begin
        merged[i] = wdata1_i[i];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (en0_i)
    begin
      rdata0_o <= mem[addr0_i];
    end
    if (en1_i)
    begin
      if (|we1_i)
      begin
        mem[addr1_i] <= merged;
      end
      rdata1_o <= merged;  // write-first
    end
  end

endmodule

// File: verilog/dcache_pkg.sv
// fixed geometry of four ways by 256 sets by 16-byte lines; the bank skew needs NUM_WAYS == LINE_WORDS
package dcache_pkg;

  localparam int NUM_WAYS   = 4;
  localparam int NUM_SETS   = 256;
  localparam int LINE_WORDS = 4;
  localparam int WORD_W     = 32;
  localparam int TAG_W      = 20;  // addr[31:12]
  localparam int IDX_W      = 8;   // addr[11:4]
  localparam int WAY_W      = 2;
  localparam int WSEL_W     = 2;   // word within line, addr[3:2]
  localparam int OFF_W      = 2;   // byte within word
  localparam int WSTRB_W    = WORD_W / 8;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } cache_tag_t;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [IDX_W-1:0]  index;
    logic [WSEL_W-1:0] word;
    logic [OFF_W-1:0]  boff;
  } cache_addr_t;

  // cpu load port
  typedef struct packed {
    cache_addr_t addr;
  } load_req_t;

  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic              hit;
    logic [WAY_W-1:0]  way;
  } load_rsp_t;

  // refill / writeback side, whole line per request
  typedef struct packed {
    cache_addr_t                           addr;   // tag and index only
    logic [WAY_W-1:0]                      way;
    logic                                  write;
    logic [LINE_WORDS-1:0][WSTRB_W-1:0]    strb;
    logic [LINE_WORDS-1:0][WORD_W-1:0]     data;
  } line_req_t;

  typedef struct packed {
    cache_tag_t                            tag;
    logic [LINE_WORDS-1:0][WORD_W-1:0]     data;
  } line_rsp_t;

endpackage
